// File: Makefile
# Verilator build and run of the control unit testbench

SOURCES := $(shell cat build.f)

.PHONY: run clean

run: obj_dir/Vtb_proc_ctrl proc_ctrl_vectors.txt
	./obj_dir/Vtb_proc_ctrl

obj_dir/Vtb_proc_ctrl: build.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_proc_ctrl -f build.f

clean:
	rm -rf obj_dir

// File: build.f
proc_ctrl_pkg.sv
pipe_ifs.sv
decode_stage.sv
exec_mem_pipe.sv
writeback_stage.sv
proc_ctrl_top.sv
tb_proc_ctrl.sv

// File: decode_stage.sv
//------------------------------
// D stage valid and instruction registers,
// decode table, hazard and manager input stall
//------------------------------

`timescale 1ns/1ps

module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 inst_val,
  input  proc_ctrl_pkg::inst_t inst,
  output logic                 inst_rdy,
  input  logic                 mngr2proc_val,
  output logic                 mngr2proc_rdy,
  stage_if.up                  out_stage,
  sb_if.dec                    sb
);

  logic                     val_d;
  proc_ctrl_pkg::inst_t     inst_d;
  proc_ctrl_pkg::dec_t      dec;
  proc_ctrl_pkg::reg_addr_t rs1;
  proc_ctrl_pkg::reg_addr_t rs2;
  logic                     is_csrr;
  logic                     ostall_mngr;
  logic                     ostall_hazard;
  logic                     ostall_d;
  logic                     stall_d;

  // one row of the control table
  function automatic proc_ctrl_pkg::dec_t cs(
    input logic                      ok,
    input logic                      r1_en,
    input logic                      r2_en,
    input logic                      wen,
    input proc_ctrl_pkg::mngr_role_t role
  );
    proc_ctrl_pkg::dec_t d;
    d.inst_ok   = ok;
    d.rs1_en    = r1_en;
    d.rs2_en    = r2_en;
    d.rf_wen    = wen;
    d.mngr_role = role;
    return d;
  endfunction

  // source matches one pending nonzero write
  function automatic logic raw_hit(
    input proc_ctrl_pkg::reg_addr_t src,
    input logic                     wen,
    input proc_ctrl_pkg::reg_addr_t waddr
  );
    return wen && (waddr == src) && (waddr != proc_ctrl_pkg::reg_zero);
  endfunction

  //------------------------------
  // pipeline registers
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (!stall_d) begin
      val_d <= inst_val;
    end
  end

  // payload only meaningful under val_d
  always_ff @(posedge clk) begin
    if (!stall_d) begin
      inst_d <= inst;
    end
  end

  //------------------------------
  // decode
  //------------------------------

  always_comb begin
    casez (inst_d)
      //                                                               ok   rs1  rs2  wen
      proc_ctrl_pkg::inst_nop:
        dec = cs(1'b1, 1'b0, 1'b0, 1'b0, proc_ctrl_pkg::mngr_none);
      // add sll slt sltu xor srl or and
      {7'b0000000, 10'b?, 3'b???, 5'b?, proc_ctrl_pkg::opcode_op}:
        dec = cs(1'b1, 1'b1, 1'b1, 1'b1, proc_ctrl_pkg::mngr_none);
      // sub
      {7'b0100000, 10'b?, 3'b000, 5'b?, proc_ctrl_pkg::opcode_op}:
        dec = cs(1'b1, 1'b1, 1'b1, 1'b1, proc_ctrl_pkg::mngr_none);
      // sra
      {7'b0100000, 10'b?, 3'b101, 5'b?, proc_ctrl_pkg::opcode_op}:
        dec = cs(1'b1, 1'b1, 1'b1, 1'b1, proc_ctrl_pkg::mngr_none);
      // csrr rd, mngr2proc
      {proc_ctrl_pkg::csr_mngr2proc, 5'b00000, proc_ctrl_pkg::funct3_csrr, 5'b?,
       proc_ctrl_pkg::opcode_system}:
        dec = cs(1'b1, 1'b0, 1'b0, 1'b1, proc_ctrl_pkg::mngr_rd);
      // csrw proc2mngr, rs1
      {proc_ctrl_pkg::csr_proc2mngr, 5'b?, proc_ctrl_pkg::funct3_csrw, 5'b00000,
       proc_ctrl_pkg::opcode_system}:
        dec = cs(1'b1, 1'b1, 1'b0, 1'b0, proc_ctrl_pkg::mngr_wr);
      // anything else still flows down and commits without a write
      default:
        dec = cs(1'b0, 1'b0, 1'b0, 1'b0, proc_ctrl_pkg::mngr_none);
    endcase
  end

  assign rs1 = inst_d[19:15];
  assign rs2 = inst_d[24:20];

  //------------------------------
  // stall
  //------------------------------

  // no bypass so wait for the producer to leave W
  assign ostall_hazard =
    (dec.rs1_en && (raw_hit(rs1, sb.x_wen, sb.x_waddr) ||
                    raw_hit(rs1, sb.m_wen, sb.m_waddr) ||
                    raw_hit(rs1, sb.w_wen, sb.w_waddr))) ||
    (dec.rs2_en && (raw_hit(rs2, sb.x_wen, sb.x_waddr) ||
                    raw_hit(rs2, sb.m_wen, sb.m_waddr) ||
                    raw_hit(rs2, sb.w_wen, sb.w_waddr)));

  // csrr waits for a manager word
  assign is_csrr     = (dec.mngr_role == proc_ctrl_pkg::mngr_rd);
  assign ostall_mngr = is_csrr && !mngr2proc_val;

  assign ostall_d = val_d && (ostall_mngr || ostall_hazard);
  assign stall_d  = val_d && (ostall_d || out_stage.stall);

  // empty or moving
  assign inst_rdy      = !stall_d;
  // consume the manager word as the csrr leaves
  assign mngr2proc_rdy = val_d && !stall_d && is_csrr;

  // hand over to X
  assign out_stage.val      = val_d && !ostall_d;
  assign out_stage.rf_wen   = dec.rf_wen;
  assign out_stage.rf_waddr = inst_d[11:7];
  assign out_stage.to_mngr  = (dec.mngr_role == proc_ctrl_pkg::mngr_wr);

  // a manager word is only taken by a real csrr of mngr2proc sitting in D
  a_mngr2proc_rdy: assert property (@(posedge clk) disable iff (reset)
    mngr2proc_rdy |-> (val_d && dec.inst_ok &&
                       inst_d[6:0] == proc_ctrl_pkg::opcode_system &&
                       inst_d[14:12] == proc_ctrl_pkg::funct3_csrr &&
                       inst_d[31:20] == proc_ctrl_pkg::csr_mngr2proc))
    else $error("mngr2proc_rdy without a valid csrr in D");

endmodule

// File: exec_mem_pipe.sv
//------------------------------
// X and M stage control registers
//------------------------------

`timescale 1ns/1ps

module exec_mem_pipe (
  input  logic  clk,
  input  logic  reset,
  stage_if.down in_stage,
  stage_if.up   out_stage,
  sb_if.pipe    sb
);

  logic                     val_x;
  logic                     rf_wen_x;
  proc_ctrl_pkg::reg_addr_t rf_waddr_x;
  logic                     to_mngr_x;
  logic                     val_m;
  logic                     rf_wen_m;
  proc_ctrl_pkg::reg_addr_t rf_waddr_m;
  logic                     to_mngr_m;
  logic                     stall_x;
  logic                     stall_m;

  // a stage only stalls when it holds something that cannot move,
  // so an empty stage keeps filling behind a blocked one
  assign stall_m = val_m && out_stage.stall;
  assign stall_x = val_x && stall_m;

  assign in_stage.stall = stall_x;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
      val_m <= 1'b0;
    end else begin
      if (!stall_x) val_x <= in_stage.val;
      if (!stall_m) val_m <= val_x;
    end
  end

  // control payload
  always_ff @(posedge clk) begin
    if (!stall_x) begin
      rf_wen_x   <= in_stage.rf_wen;
      rf_waddr_x <= in_stage.rf_waddr;
      to_mngr_x  <= in_stage.to_mngr;
    end
    if (!stall_m) begin
      rf_wen_m   <= rf_wen_x;
      rf_waddr_m <= rf_waddr_x;
      to_mngr_m  <= to_mngr_x;
    end
  end

  // scoreboard entries
  assign sb.x_wen   = val_x && rf_wen_x;
  assign sb.x_waddr = rf_waddr_x;
  assign sb.m_wen   = val_m && rf_wen_m;
  assign sb.m_waddr = rf_waddr_m;

  assign out_stage.val      = val_m;
  assign out_stage.rf_wen   = rf_wen_m;
  assign out_stage.rf_waddr = rf_waddr_m;
  assign out_stage.to_mngr  = to_mngr_m;

  // W back-pressure must freeze what M offers
  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    (out_stage.val && out_stage.stall) |=>
      $stable({out_stage.val, out_stage.rf_wen, out_stage.rf_waddr, out_stage.to_mngr}))
    else $error("M stage data changed under W stall");

endmodule

// File: pipe_ifs.sv
//------------------------------
// stage_if between pipeline stages
// sb_if pending write scoreboard
//------------------------------

`timescale 1ns/1ps

// one stage to the next
// a transfer happens on a rising edge with val high and stall low,
// the data holds while stall is high
interface stage_if;

  logic                     val;
  // runs backward, driven by the receiving stage
  logic                     stall;
  logic                     rf_wen;
  proc_ctrl_pkg::reg_addr_t rf_waddr;
  // csrw to proc2mngr
  logic                     to_mngr;

  modport up   (output val, rf_wen, rf_waddr, to_mngr, input stall);
  modport down (input val, rf_wen, rf_waddr, to_mngr, output stall);

endinterface

// pending register writes in X, M and W
// every wen already has the stage valid bit folded in
interface sb_if;

  logic                     x_wen;
  proc_ctrl_pkg::reg_addr_t x_waddr;
  logic                     m_wen;
  proc_ctrl_pkg::reg_addr_t m_waddr;
  logic                     w_wen;
  proc_ctrl_pkg::reg_addr_t w_waddr;

  // X and M entries
  modport pipe (output x_wen, x_waddr, m_wen, m_waddr);
  // W entry
  modport wb   (output w_wen, w_waddr);
  // hazard check in D
  modport dec  (input x_wen, x_waddr, m_wen, m_waddr, w_wen, w_waddr);

endinterface

// File: proc_ctrl_pkg.sv
//------------------------------
// shared widths, instruction and csr encodings,
// manager role enum and decode result struct
//------------------------------

package proc_ctrl_pkg;

  //------------------------------
  // widths that carry a meaning
  //------------------------------

  // full instruction word
  typedef logic [31:0] inst_t;

  // register specifier, rd / rs1 / rs2
  typedef logic [4:0] reg_addr_t;

  // csr number in bits 31:20 of a system instruction
  typedef logic [11:0] csr_addr_t;

  // what an instruction does with the manager ports
  typedef enum logic [1:0] {
    mngr_none = 2'd0,
    mngr_rd   = 2'd1,
    mngr_wr   = 2'd2
  } mngr_role_t;

  // decode result, carried through the D stage only
  typedef struct packed {
    logic       inst_ok;
    logic       rs1_en;
    logic       rs2_en;
    logic       rf_wen;
    mngr_role_t mngr_role;
  } dec_t;

  //------------------------------
  // encodings
  //------------------------------

  // major opcodes
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // csrr is csrrs with rs1 = x0, csrw is csrrw with rd = x0
  localparam logic [2:0] funct3_csrr = 3'b010;
  localparam logic [2:0] funct3_csrw = 3'b001;

  // manager registers
  localparam csr_addr_t csr_mngr2proc = 12'hfc0;
  localparam csr_addr_t csr_proc2mngr = 12'h7c0;

  // x0 is hardwired, a write to it never blocks a reader
  localparam reg_addr_t reg_zero = 5'd0;

  // addi x0, x0, 0
  localparam inst_t inst_nop = 32'h0000_0013;

endpackage

// File: proc_ctrl_top.sv
//------------------------------
// control unit top, D -> X/M -> W
//------------------------------

`timescale 1ns/1ps

module proc_ctrl_top (
  input  logic                     clk,
  input  logic                     reset,
  // instruction stream
  input  logic                     inst_val,
  input  proc_ctrl_pkg::inst_t     inst,
  output logic                     inst_rdy,
  // manager ports
  input  logic                     mngr2proc_val,
  output logic                     mngr2proc_rdy,
  output logic                     proc2mngr_val,
  input  logic                     proc2mngr_rdy,
  // commit side
  output logic                     rf_wen,
  output proc_ctrl_pkg::reg_addr_t rf_waddr,
  output logic                     commit
);

  stage_if d2x ();
  stage_if x2w ();
  sb_if    sb  ();

  decode_stage u_decode (
    .clk           (clk),
    .reset         (reset),
    .inst_val      (inst_val),
    .inst          (inst),
    .inst_rdy      (inst_rdy),
    .mngr2proc_val (mngr2proc_val),
    .mngr2proc_rdy (mngr2proc_rdy),
    .out_stage     (d2x),
    .sb            (sb)
  );

  exec_mem_pipe u_exec_mem (
    .clk       (clk),
    .reset     (reset),
    .in_stage  (d2x),
    .out_stage (x2w),
    .sb        (sb)
  );

  writeback_stage u_writeback (
    .clk           (clk),
    .reset         (reset),
    .proc2mngr_rdy (proc2mngr_rdy),
    .proc2mngr_val (proc2mngr_val),
    .rf_wen        (rf_wen),
    .rf_waddr      (rf_waddr),
    .commit        (commit),
    .in_stage      (x2w),
    .sb            (sb)
  );

endmodule

// File: proc_ctrl_vectors.txt
// columns: instruction word, expected rf_wen, expected rf_waddr (checked when rf_wen is 1),
// manager role (0 none, 1 csrr mngr2proc, 2 csrw proc2mngr)
00000013 0 00 0  // nop
fc0020f3 1 01 1  // csrr x1, mngr2proc
fc002173 1 02 1  // csrr x2, mngr2proc
002081b3 1 03 0  // add x3, x1, x2
40118233 1 04 0  // sub x4, x3, x1
7c021073 0 00 2  // csrw proc2mngr, x4
ffffffff 0 00 0  // invalid opcode
004192b3 1 05 0  // sll x5, x3, x4
0052a333 1 06 0  // slt x6, x5, x5
0020b3b3 1 07 0  // sltu x7, x1, x2
00734433 1 08 0  // xor x8, x6, x7
001454b3 1 09 0  // srl x9, x8, x1
4024d533 1 0a 0  // sra x10, x9, x2
000565b3 1 0b 0  // or x11, x10, x0
00a5f633 1 0c 0  // and x12, x11, x10
7c061073 0 00 2  // csrw proc2mngr, x12
00208033 1 00 0  // add x0, x1, x2
400010b3 0 00 0  // invalid, funct7 0100000 with funct3 001
7c002073 0 00 0  // invalid, csrr form on proc2mngr
00108093 0 00 0  // invalid, addi x1, x1, 1
fc0026f3 1 0d 1  // csrr x13, mngr2proc
7c069073 0 00 2  // csrw proc2mngr, x13
00d68733 1 0e 0  // add x14, x13, x13

// File: tb_proc_ctrl.sv
//------------------------------
// testbench for proc_ctrl_top with vector file stimulus,
// LFSR handshakes, in-order commit model
//------------------------------

`timescale 1ns/1ps

module tb_proc_ctrl;

  localparam int clk_period  = 40;
  localparam int num_vectors = 23;
  localparam int max_cycles  = 5000;
  localparam int drain_limit = 400;

  logic                     clk;
  logic                     reset;
  logic                     inst_val;
  proc_ctrl_pkg::inst_t     inst;
  logic                     inst_rdy;
  logic                     mngr2proc_val;
  logic                     mngr2proc_rdy;
  logic                     proc2mngr_val;
  logic                     proc2mngr_rdy;
  logic                     rf_wen;
  proc_ctrl_pkg::reg_addr_t rf_waddr;
  logic                     commit;

  // four words per vector in the order inst wen waddr role
  logic [31:0] vec_mem [0:4*num_vectors-1];
  // set when a vector left D while an older matching write was outstanding
  logic        hazard_seen [0:num_vectors-1];
  // accepted but not yet committed, oldest first
  int          in_flight[$];
  logic [15:0] lfsr;
  // newest accepted vector not yet known to be out of D or -1
  int          in_d;
  int          next_vec;
  int          n_commit;
  int          n_m2p_pulse;
  int          n_p2m_xfer;
  int          exp_csrr;
  int          exp_csrw;
  int          cycles;
  int          drain;

  proc_ctrl_top dut (
    .clk           (clk),
    .reset         (reset),
    .inst_val      (inst_val),
    .inst          (inst),
    .inst_rdy      (inst_rdy),
    .mngr2proc_val (mngr2proc_val),
    .mngr2proc_rdy (mngr2proc_rdy),
    .proc2mngr_val (proc2mngr_val),
    .proc2mngr_rdy (proc2mngr_rdy),
    .rf_wen        (rf_wen),
    .rf_waddr      (rf_waddr),
    .commit        (commit)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  //------------------------------
  // helpers
  //------------------------------

  // taps x^16 + x^14 + x^13 + x^11 + 1
  // new bit enters at bit 0
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // consumer c reads the nonzero destination of producer p
  // ALU ops read rs1 and rs2 and csrw reads rs1
  // csrr nop and invalid read nothing
  function automatic logic depends_on(input int c, input int p);
    proc_ctrl_pkg::inst_t     w;
    proc_ctrl_pkg::reg_addr_t rd;
    logic                     alu;
    logic                     wr;
    w   = vec_mem[4*c];
    rd  = vec_mem[4*p+2][4:0];
    alu = vec_mem[4*c+1][0] && (vec_mem[4*c+3][1:0] == 2'd0);
    wr  = (vec_mem[4*c+3][1:0] == 2'd2);
    if (!vec_mem[4*p+1][0] || rd == proc_ctrl_pkg::reg_zero) return 1'b0;
    return ((alu || wr) && w[19:15] == rd) || (alu && w[24:20] == rd);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_wen(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("error %s: expected %0b, actual %0b", name, exp, act));
  endtask

  task automatic check_waddr(input string name, input proc_ctrl_pkg::reg_addr_t exp,
                             input proc_ctrl_pkg::reg_addr_t act);
    if (act !== exp)
      abort_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
      abort_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
  endtask

  // empty pipeline
  task automatic check_idle(input string name);
    check_wen({name, " commit"}, 1'b0, commit);
    check_wen({name, " rf_wen"}, 1'b0, rf_wen);
    check_wen({name, " proc2mngr_val"}, 1'b0, proc2mngr_val);
    check_wen({name, " mngr2proc_rdy"}, 1'b0, mngr2proc_rdy);
    check_wen({name, " inst_rdy"}, 1'b1, inst_rdy);
  endtask

  task automatic drive_inputs();
    lfsr     = lfsr_step(lfsr);
    inst_val = lfsr[0] && (next_vec < num_vectors);
    inst     = (next_vec < num_vectors) ? vec_mem[4*next_vec] : proc_ctrl_pkg::inst_nop;
    lfsr          = lfsr_step(lfsr);
    mngr2proc_val = lfsr[0];
    lfsr          = lfsr_step(lfsr);
    proc2mngr_rdy = lfsr[0];
  endtask

  // mark c if an older write it should have waited for is still pending
  task automatic leave_decode(input int c);
    foreach (in_flight[i]) begin
      if (in_flight[i] < c && depends_on(c, in_flight[i])) hazard_seen[c] = 1'b1;
    end
  endtask

  task automatic retire_head();
    int    h;
    string name;
    h = in_flight.pop_front();
    if (h == in_d) in_d = -1;
    name = $sformatf("vector %0d", h);
    check_wen({name, " rf_wen"}, vec_mem[4*h+1][0], rf_wen);
    if (vec_mem[4*h+1][0]) check_waddr({name, " rf_waddr"}, vec_mem[4*h+2][4:0], rf_waddr);
    if (hazard_seen[h])
      abort_run({name, " left decode while an older write to its source was pending"});
    if (vec_mem[4*h+3][1:0] == 2'd2) begin
      if (!(proc2mngr_val && proc2mngr_rdy))
        abort_run({name, " is a csrw that committed without a proc2mngr transfer"});
    end
    n_commit++;
  endtask

  // one cycle sampled ahead of the rising edge
  task automatic observe_cycle();
    logic accepted;
    accepted = inst_val && inst_rdy;
    if (mngr2proc_rdy) begin
      n_m2p_pulse++;
      if (!mngr2proc_val) abort_run("mngr2proc_rdy pulsed while mngr2proc_val was low");
    end
    if (proc2mngr_val && !proc2mngr_rdy && commit)
      abort_run("an instruction committed while a csrw waited for proc2mngr_rdy");
    if (proc2mngr_val && proc2mngr_rdy) begin
      n_p2m_xfer++;
      if (!commit || in_flight.size() == 0 || vec_mem[4*in_flight[0]+3][1:0] != 2'd2)
        abort_run("proc2mngr transfer that is not the oldest csrw committing");
    end
    if (!commit) check_wen("rf_wen outside commit", 1'b0, rf_wen);
    // leaving D is checked before this edge's commit drops the producer
    if (accepted && in_d >= 0) leave_decode(in_d);
    if (commit) begin
      if (in_flight.size() == 0) abort_run("commit with no accepted instruction outstanding");
      retire_head();
    end
    if (accepted) begin
      in_flight.push_back(next_vec);
      in_d = next_vec;
      next_vec++;
    end
  endtask

  //------------------------------
  // main sequence
  //------------------------------

  initial begin
    reset         = 1'b1;
    inst_val      = 1'b0;
    inst          = proc_ctrl_pkg::inst_nop;
    mngr2proc_val = 1'b0;
    proc2mngr_rdy = 1'b0;
    lfsr          = 16'd87;
    in_d          = -1;
    next_vec      = 0;
    n_commit      = 0;
    n_m2p_pulse   = 0;
    n_p2m_xfer    = 0;
    exp_csrr      = 0;
    exp_csrw      = 0;
    cycles        = 0;
    drain         = 0;
    $readmemh("proc_ctrl_vectors.txt", vec_mem);
    for (int i = 0; i < num_vectors; i++) begin
      hazard_seen[i] = 1'b0;
      if ($isunknown(vec_mem[4*i]) || vec_mem[4*i+3] > 32'd2)
        abort_run("vector file is short or holds a bad manager role");
      if (vec_mem[4*i+3] == 32'd1) exp_csrr++;
      if (vec_mem[4*i+3] == 32'd2) exp_csrw++;
    end

    // 10 rising edges under reset
    repeat (10) begin
      @(posedge clk);
      #(clk_period/4);
      check_idle("reset");
    end

    while (n_commit < num_vectors) begin
      @(negedge clk);
      reset = 1'b0;
      drive_inputs();
      #(clk_period/4);
      if (cycles == 0) check_idle("after reset");
      observe_cycle();
      cycles++;
      if (next_vec == num_vectors) drain++;
      if (cycles > max_cycles) abort_run("timed out before all vectors were accepted");
      if (drain > drain_limit) abort_run("timed out waiting for the pipeline to drain");
    end

    // nothing may be left behind the last commit
    @(negedge clk);
    #(clk_period/4);
    check_idle("drained");

    check_count("mngr2proc_rdy pulses", exp_csrr, n_m2p_pulse);
    check_count("proc2mngr transfers", exp_csrw, n_p2m_xfer);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: writeback_stage.sv
//------------------------------
// W stage: register write, commit,
// proc2mngr back-pressure
//------------------------------

`timescale 1ns/1ps

module writeback_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     proc2mngr_rdy,
  output logic                     proc2mngr_val,
  output logic                     rf_wen,
  output proc_ctrl_pkg::reg_addr_t rf_waddr,
  output logic                     commit,
  stage_if.down                    in_stage,
  sb_if.wb                         sb
);

  logic                     val_w;
  logic                     rf_wen_w;
  proc_ctrl_pkg::reg_addr_t rf_waddr_w;
  logic                     to_mngr_w;
  logic                     stall_w;

  // csrw holds W until the manager takes the word
  assign stall_w        = val_w && to_mngr_w && !proc2mngr_rdy;
  assign in_stage.stall = stall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (!stall_w) begin
      val_w <= in_stage.val;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_w) begin
      rf_wen_w   <= in_stage.rf_wen;
      rf_waddr_w <= in_stage.rf_waddr;
      to_mngr_w  <= in_stage.to_mngr;
    end
  end

  // level, independent of rdy
  assign proc2mngr_val = val_w && to_mngr_w;

  assign commit   = val_w && !stall_w;
  assign rf_wen   = commit && rf_wen_w;
  assign rf_waddr = rf_waddr_w;

  // pending write stays visible to D until commit
  assign sb.w_wen   = val_w && rf_wen_w;
  assign sb.w_waddr = rf_waddr_w;

  a_p2m_hold: assert property (@(posedge clk) disable iff (reset)
    (proc2mngr_val && !proc2mngr_rdy) |=> proc2mngr_val)
    else $error("proc2mngr_val dropped before it was accepted");

endmodule
